// File: sld_pkg.sv
`default_nettype none

package sld_pkg;

   //////////////////////////////////////////////////////////////////////
   // lanes and register file
   localparam int unsigned VLANE_NUM = 8;
   localparam int unsigned LANE_W    = $clog2(VLANE_NUM);
   localparam int unsigned MEM_DEPTH = 512;                 // words per lane
   localparam int unsigned ADDR_W    = $clog2(MEM_DEPTH);
   localparam int unsigned VL_W      = 11;                  // vector length in elements
   localparam int unsigned CNT_W     = 9;                   // per-lane steps and delay

   // command queue, depth equals the credit count
   localparam int unsigned CMD_DEPTH = 2;
   localparam int unsigned CMD_PTR_W = $clog2(CMD_DEPTH);
   localparam int unsigned CMD_CNT_W = $clog2(CMD_DEPTH + 1);

   //////////////////////////////////////////////////////////////////////
   // instruction kinds, code 3 retires with no activity
   localparam int unsigned KIND_W = 2;
   localparam logic [KIND_W-1:0] KIND_NORMAL = 2'd0;
   localparam logic [KIND_W-1:0] KIND_STORE  = 2'd1;
   localparam logic [KIND_W-1:0] KIND_LOAD   = 2'd2;

   // element width
   localparam int unsigned SEW_W = 2;
   localparam logic [SEW_W-1:0] SEW_BYTE = 2'd0;
   localparam logic [SEW_W-1:0] SEW_HALF = 2'd1;
   localparam logic [SEW_W-1:0] SEW_WORD = 2'd2;

   // sequencer states
   localparam int unsigned ST_W = 2;
   localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;
   localparam logic [ST_W-1:0] ST_RUN   = 2'd1;               // normal, reads and writes
   localparam logic [ST_W-1:0] ST_STORE = 2'd2;
   localparam logic [ST_W-1:0] ST_LOAD  = 2'd3;

endpackage

`default_nettype wire

// File: sld_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sld_cmd_queue (
   input  logic                         clk_i,
   input  logic                         rstn_i,
   input  logic                         cmd_valid_i,
   input  logic [sld_pkg::KIND_W-1:0]   cmd_kind_i,
   input  logic [sld_pkg::VL_W-1:0]     cmd_vl_i,
   input  logic [sld_pkg::SEW_W-1:0]    cmd_sew_i,
   input  logic [sld_pkg::CNT_W-1:0]    cmd_delay_i,
   input  logic [sld_pkg::ADDR_W-1:0]   cmd_raddr_i,
   input  logic [sld_pkg::ADDR_W-1:0]   cmd_waddr_i,
   input  logic                         pop_i,
   output logic                         credit_o,
   output logic                         valid_o,
   output logic [sld_pkg::KIND_W-1:0]   kind_o,
   output logic [sld_pkg::VL_W-1:0]     vl_o,
   output logic [sld_pkg::SEW_W-1:0]    sew_o,
   output logic [sld_pkg::CNT_W-1:0]    delay_o,
   output logic [sld_pkg::ADDR_W-1:0]   raddr_o,
   output logic [sld_pkg::ADDR_W-1:0]   waddr_o
);

   logic [sld_pkg::KIND_W-1:0] kind_mem  [sld_pkg::CMD_DEPTH];
   logic [sld_pkg::VL_W-1:0]   vl_mem    [sld_pkg::CMD_DEPTH];
   logic [sld_pkg::SEW_W-1:0]  sew_mem   [sld_pkg::CMD_DEPTH];
   logic [sld_pkg::CNT_W-1:0]  delay_mem [sld_pkg::CMD_DEPTH];
   logic [sld_pkg::ADDR_W-1:0] raddr_mem [sld_pkg::CMD_DEPTH];
   logic [sld_pkg::ADDR_W-1:0] waddr_mem [sld_pkg::CMD_DEPTH];

   logic [sld_pkg::CMD_PTR_W-1:0] wr_ptr, rd_ptr;
   logic [sld_pkg::CMD_CNT_W-1:0] count;

   function automatic logic [sld_pkg::CMD_PTR_W-1:0] ptr_inc(
      input logic [sld_pkg::CMD_PTR_W-1:0] ptr
   );
      return (ptr == sld_pkg::CMD_DEPTH - 1) ? '0 : ptr + 1'b1;
   endfunction

   assign valid_o = (count != '0);
   assign kind_o  = kind_mem[rd_ptr];
   assign vl_o    = vl_mem[rd_ptr];
   assign sew_o   = sew_mem[rd_ptr];
   assign delay_o = delay_mem[rd_ptr];
   assign raddr_o = raddr_mem[rd_ptr];
   assign waddr_o = waddr_mem[rd_ptr];

   // dispatcher never writes without a credit, so no full check
   always_ff @(posedge clk_i) begin
      if (cmd_valid_i) begin
         kind_mem[wr_ptr]  <= cmd_kind_i;
         vl_mem[wr_ptr]    <= cmd_vl_i;
         sew_mem[wr_ptr]   <= cmd_sew_i;
         delay_mem[wr_ptr] <= cmd_delay_i;
         raddr_mem[wr_ptr] <= cmd_raddr_i;
         waddr_mem[wr_ptr] <= cmd_waddr_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         credit_o <= pop_i;                        // one credit back per pop
         if (cmd_valid_i) wr_ptr <= ptr_inc(wr_ptr);
         if (pop_i) rd_ptr <= ptr_inc(rd_ptr);
         count <= count + cmd_valid_i - pop_i;
      end
   end

endmodule

`default_nettype wire

// File: sld_elem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sld_elem_sequencer (
   input  logic                        clk_i,
   input  logic                        rstn_i,
   input  logic                        q_valid_i,
   input  logic [sld_pkg::KIND_W-1:0]  kind_i,
   input  logic [sld_pkg::VL_W-1:0]    vl_i,
   input  logic [sld_pkg::CNT_W-1:0]   delay_i,
   input  logic                        load_valid_i,
   input  logic                        load_last_i,
   output logic                        q_pop_o,
   output logic                        start_o,
   output logic                        rd_step_o,
   output logic [sld_pkg::CNT_W-1:0]   rd_idx_o,
   output logic                        wr_step_o,
   output logic [sld_pkg::CNT_W-1:0]   wr_idx_o,
   output logic                        ld_step_o,
   output logic                        store_o,
   output logic                        ready_for_load_o
);

   logic [sld_pkg::ST_W-1:0]  state_q, state_d;
   logic [sld_pkg::CNT_W-1:0] n_q, dly_q, rd_q, wr_q, wt_q;
   logic [sld_pkg::CNT_W-1:0] n_head, n_cur, dly_cur, rd_cur, wr_cur, wt_cur;
   logic                      busy, rd_mode, wr_mode, st_mode, retire;

   assign q_pop_o = (state_q == sld_pkg::ST_IDLE) && q_valid_i;
   assign start_o = q_pop_o;
   assign busy    = q_pop_o || (state_q != sld_pkg::ST_IDLE);

   // steps per lane, ceil(vl / lanes)
   assign n_head = vl_i[sld_pkg::VL_W-1:sld_pkg::LANE_W] + (vl_i[sld_pkg::LANE_W-1:0] != '0);

   //////////////////////////////////////////////////////////////////////
   // in the pop cycle the head fields stand in for the registers
   assign n_cur   = q_pop_o ? n_head  : n_q;
   assign dly_cur = q_pop_o ? delay_i : dly_q;
   assign rd_cur  = q_pop_o ? '0 : rd_q;
   assign wr_cur  = q_pop_o ? '0 : wr_q;
   assign wt_cur  = q_pop_o ? '0 : wt_q;        // cycles since pop, stops at delay

   assign wr_mode = (q_pop_o && kind_i == sld_pkg::KIND_NORMAL) || state_q == sld_pkg::ST_RUN;
   assign st_mode = (q_pop_o && kind_i == sld_pkg::KIND_STORE) || state_q == sld_pkg::ST_STORE;
   assign rd_mode = wr_mode || st_mode;

   assign rd_step_o = rd_mode && (rd_cur < n_cur);
   assign rd_idx_o  = rd_cur;
   assign wr_step_o = wr_mode && (wt_cur == dly_cur) && (wr_cur < n_cur);
   assign wr_idx_o  = wr_cur;

   assign ready_for_load_o = (state_q == sld_pkg::ST_LOAD);
   assign ld_step_o        = ready_for_load_o && load_valid_i;

   // last write, last store read or last load beat
   assign retire = (wr_mode && (n_cur == '0 || (wr_step_o && wr_cur == n_cur - 1'b1)))
                || (st_mode && (n_cur == '0 || (rd_step_o && rd_cur == n_cur - 1'b1)))
                || (ld_step_o && load_last_i);

   always_comb begin
      state_d = state_q;
      if (retire) begin
         state_d = sld_pkg::ST_IDLE;
      end else if (q_pop_o) begin
         case (kind_i)
            sld_pkg::KIND_NORMAL: state_d = sld_pkg::ST_RUN;
            sld_pkg::KIND_STORE:  state_d = sld_pkg::ST_STORE;
            sld_pkg::KIND_LOAD:   state_d = sld_pkg::ST_LOAD;
            default:              state_d = sld_pkg::ST_IDLE;   // unused code
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_q <= sld_pkg::ST_IDLE;
         rd_q    <= '0;
         wr_q    <= '0;
         wt_q    <= '0;
         store_o <= 1'b0;
      end else begin
         state_q <= state_d;
         store_o <= st_mode && rd_step_o;
         if (busy) begin
            rd_q <= rd_cur + rd_step_o;
            wr_q <= wr_cur + wr_step_o;
            wt_q <= wt_cur + (wt_cur != dly_cur);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (q_pop_o) begin
         n_q   <= n_head;
         dly_q <= delay_i;
      end
   end

endmodule

`default_nettype wire

// File: sld_vrf_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sld_vrf_addr_gen (
   input  logic                        clk_i,
   input  logic                        rstn_i,
   input  logic                        start_i,
   input  logic [sld_pkg::ADDR_W-1:0]  raddr_i,
   input  logic [sld_pkg::ADDR_W-1:0]  waddr_i,
   input  logic [sld_pkg::SEW_W-1:0]   sew_i,
   input  logic                        rd_step_i,
   input  logic [sld_pkg::CNT_W-1:0]   rd_idx_i,
   input  logic                        wr_step_i,
   input  logic [sld_pkg::CNT_W-1:0]   wr_idx_i,
   input  logic                        ld_step_i,
   output logic [sld_pkg::ADDR_W-1:0]  vrf_raddr_o,
   output logic [sld_pkg::ADDR_W-1:0]  vrf_waddr_o,
   output logic                        vrf_ren_o
);

   logic [sld_pkg::ADDR_W-1:0] raddr_q, waddr_q, rbase, wbase, beat_q;
   logic [sld_pkg::SEW_W-1:0]  sew_q, sew_cur;
   logic [1:0]                 sh;

   // first step comes in the start cycle itself
   assign rbase   = start_i ? raddr_i : raddr_q;
   assign wbase   = start_i ? waddr_i : waddr_q;
   assign sew_cur = start_i ? sew_i   : sew_q;

   // elements packed per word: 4, 2 or 1
   always_comb begin
      case (sew_cur)
         sld_pkg::SEW_BYTE: sh = 2'd2;
         sld_pkg::SEW_HALF: sh = 2'd1;
         default:           sh = 2'd0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         raddr_q <= raddr_i;
         waddr_q <= waddr_i;
         sew_q   <= sew_i;
      end
      if (rd_step_i) vrf_raddr_o <= rbase + (rd_idx_i >> sh);
      if (wr_step_i) vrf_waddr_o <= wbase + (wr_idx_i >> sh);
      else if (ld_step_i) vrf_waddr_o <= waddr_q + beat_q;   // one word per beat
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         vrf_ren_o <= 1'b0;
         beat_q    <= '0;
      end else begin
         vrf_ren_o <= rd_step_i;
         if (start_i) beat_q <= '0;
         else if (ld_step_i) beat_q <= beat_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: sld_bwen_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sld_bwen_gen (
   input  logic                                 clk_i,
   input  logic                                 rstn_i,
   input  logic                                 start_i,
   input  logic [sld_pkg::VL_W-1:0]             vl_i,
   input  logic [sld_pkg::SEW_W-1:0]            sew_i,
   input  logic                                 rd_step_i,
   input  logic [sld_pkg::CNT_W-1:0]            rd_idx_i,
   input  logic                                 wr_step_i,
   input  logic [sld_pkg::CNT_W-1:0]            wr_idx_i,
   input  logic                                 ld_step_i,
   input  logic [sld_pkg::VLANE_NUM-1:0][3:0]   load_bwen_i,
   output logic [sld_pkg::VLANE_NUM-1:0][3:0]   vrf_bwen_o,
   output logic [sld_pkg::VLANE_NUM-1:0]        read_data_valid_o
);

   logic [sld_pkg::VL_W-1:0]      vl_q, vl_cur;
   logic [sld_pkg::SEW_W-1:0]     sew_q, sew_cur;
   logic [sld_pkg::VLANE_NUM-1:0] rd_lane_ok, wr_lane_ok;
   logic [3:0]                    pattern;

   // lane l holds element idx * lanes + l
   function automatic logic [sld_pkg::VLANE_NUM-1:0] lane_ok(
      input logic [sld_pkg::CNT_W-1:0] idx,
      input logic [sld_pkg::VL_W-1:0]  vl
   );
      logic [sld_pkg::CNT_W+sld_pkg::LANE_W-1:0] first;
      first = {idx, {sld_pkg::LANE_W{1'b0}}};
      for (int l = 0; l < sld_pkg::VLANE_NUM; l++) begin
         lane_ok[l] = (first + l) < vl;
      end
   endfunction

   assign vl_cur     = start_i ? vl_i  : vl_q;
   assign sew_cur    = start_i ? sew_i : sew_q;
   assign rd_lane_ok = lane_ok(rd_idx_i, vl_cur);
   assign wr_lane_ok = lane_ok(wr_idx_i, vl_cur);

   // byte lanes within the word, rotating with the step
   always_comb begin
      case (sew_cur)
         sld_pkg::SEW_BYTE: pattern = 4'b0001 << wr_idx_i[1:0];
         sld_pkg::SEW_HALF: pattern = wr_idx_i[0] ? 4'b1100 : 4'b0011;
         sld_pkg::SEW_WORD: pattern = 4'b1111;
         default:           pattern = 4'b0000;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         vl_q  <= vl_i;
         sew_q <= sew_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         vrf_bwen_o        <= '0;
         read_data_valid_o <= '0;
      end else begin
         read_data_valid_o <= rd_step_i ? rd_lane_ok : '0;
         for (int l = 0; l < sld_pkg::VLANE_NUM; l++) begin
            if (wr_step_i) vrf_bwen_o[l] <= wr_lane_ok[l] ? pattern : 4'b0000;
            else if (ld_step_i) vrf_bwen_o[l] <= load_bwen_i[l];   // load unit decides
            else vrf_bwen_o[l] <= 4'b0000;
         end
      end
   end

endmodule

`default_nettype wire

// File: sublane_driver.sv
`timescale 1ns/1ps
`default_nettype none

module sublane_driver (
   input  logic                                 clk_i,
   input  logic                                 rstn_i,
   input  logic                                 cmd_valid_i,
   input  logic [sld_pkg::KIND_W-1:0]           cmd_kind_i,
   input  logic [sld_pkg::VL_W-1:0]             cmd_vl_i,
   input  logic [sld_pkg::SEW_W-1:0]            cmd_sew_i,
   input  logic [sld_pkg::CNT_W-1:0]            cmd_delay_i,
   input  logic [sld_pkg::ADDR_W-1:0]           cmd_raddr_i,
   input  logic [sld_pkg::ADDR_W-1:0]           cmd_waddr_i,
   input  logic                                 load_valid_i,
   input  logic                                 load_last_i,
   input  logic [sld_pkg::VLANE_NUM-1:0][3:0]   load_bwen_i,
   output logic                                 credit_o,
   output logic                                 vrf_ren_o,
   output logic [sld_pkg::ADDR_W-1:0]           vrf_raddr_o,
   output logic [sld_pkg::ADDR_W-1:0]           vrf_waddr_o,
   output logic [sld_pkg::VLANE_NUM-1:0][3:0]   vrf_bwen_o,
   output logic [sld_pkg::VLANE_NUM-1:0]        read_data_valid_o,
   output logic                                 store_data_valid_o,
   output logic                                 ready_for_load_o
);

   // queue head
   logic                       q_valid, q_pop;
   logic [sld_pkg::KIND_W-1:0] q_kind;
   logic [sld_pkg::VL_W-1:0]   q_vl;
   logic [sld_pkg::SEW_W-1:0]  q_sew;
   logic [sld_pkg::CNT_W-1:0]  q_delay;
   logic [sld_pkg::ADDR_W-1:0] q_raddr, q_waddr;

   // sequencer strobes
   logic                       start, rd_step, wr_step, ld_step;
   logic [sld_pkg::CNT_W-1:0]  rd_idx, wr_idx;

   sld_cmd_queue i_cmd_queue (
      .clk_i, .rstn_i, .cmd_valid_i, .cmd_kind_i, .cmd_vl_i, .cmd_sew_i,
      .cmd_delay_i, .cmd_raddr_i, .cmd_waddr_i,
      .pop_i(q_pop), .credit_o, .valid_o(q_valid), .kind_o(q_kind), .vl_o(q_vl),
      .sew_o(q_sew), .delay_o(q_delay), .raddr_o(q_raddr), .waddr_o(q_waddr)
   );

   sld_elem_sequencer i_elem_sequencer (
      .clk_i, .rstn_i, .q_valid_i(q_valid), .kind_i(q_kind), .vl_i(q_vl),
      .delay_i(q_delay), .load_valid_i, .load_last_i,
      .q_pop_o(q_pop), .start_o(start), .rd_step_o(rd_step), .rd_idx_o(rd_idx),
      .wr_step_o(wr_step), .wr_idx_o(wr_idx), .ld_step_o(ld_step),
      .store_o(store_data_valid_o), .ready_for_load_o
   );

   sld_vrf_addr_gen i_vrf_addr_gen (
      .clk_i, .rstn_i, .start_i(start), .raddr_i(q_raddr), .waddr_i(q_waddr),
      .sew_i(q_sew), .rd_step_i(rd_step), .rd_idx_i(rd_idx), .wr_step_i(wr_step),
      .wr_idx_i(wr_idx), .ld_step_i(ld_step),
      .vrf_raddr_o, .vrf_waddr_o, .vrf_ren_o
   );

   sld_bwen_gen i_bwen_gen (
      .clk_i, .rstn_i, .start_i(start), .vl_i(q_vl), .sew_i(q_sew),
      .rd_step_i(rd_step), .rd_idx_i(rd_idx), .wr_step_i(wr_step), .wr_idx_i(wr_idx),
      .ld_step_i(ld_step), .load_bwen_i,
      .vrf_bwen_o, .read_data_valid_o
   );

endmodule

`default_nettype wire

// File: tb_sublane_driver.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sublane_driver;

   localparam int N_SEW = 12;
   localparam int N_DLY = 8;
   localparam int N_TAIL = 12;
   localparam int N_STLD = 16;
   localparam int N_RAND = 60;
   localparam int CMD_TOTAL = N_SEW + N_DLY + N_TAIL + N_STLD + N_RAND;
   localparam int WORST_CMD_CYC = 2 + 511 + 256 + 8 * 4;   // pop, delay, steps, gapped beats
   localparam int WATCHDOG_CYC = 16 + CMD_TOTAL * WORST_CMD_CYC + 500;

   logic                                 clk_i = 1'b0;
   logic                                 rstn_i;
   logic                                 cmd_valid_i;
   logic [sld_pkg::KIND_W-1:0]           cmd_kind_i;
   logic [sld_pkg::VL_W-1:0]             cmd_vl_i;
   logic [sld_pkg::SEW_W-1:0]            cmd_sew_i;
   logic [sld_pkg::CNT_W-1:0]            cmd_delay_i;
   logic [sld_pkg::ADDR_W-1:0]           cmd_raddr_i, cmd_waddr_i;
   logic                                 load_valid_i, load_last_i;
   logic [sld_pkg::VLANE_NUM-1:0][3:0]   load_bwen_i;
   logic                                 credit_o, vrf_ren_o;
   logic [sld_pkg::ADDR_W-1:0]           vrf_raddr_o, vrf_waddr_o;
   logic [sld_pkg::VLANE_NUM-1:0][3:0]   vrf_bwen_o;
   logic [sld_pkg::VLANE_NUM-1:0]        read_data_valid_o;
   logic                                 store_data_valid_o, ready_for_load_o;

   sublane_driver i_sublane_driver (.*);

   always #4 clk_i = ~clk_i;

   //////////////////////////////////////////////////////////////////////
   // expected outputs, keyed by cycle number
   logic [sld_pkg::ADDR_W-1:0]    exp_raddr [int];
   logic [sld_pkg::ADDR_W-1:0]    exp_waddr [int];
   logic [sld_pkg::VLANE_NUM-1:0] exp_rdv [int];
   logic [31:0]                   exp_bwen [int];
   bit                            exp_store [int];
   bit                            exp_ready [int];
   bit                            exp_credit [int];

   // model of the command queue and the sequencer
   int q_kind[$], q_vl[$], q_sew[$], q_dly[$], q_ra[$], q_wa[$], q_rdy[$];
   int cyc = 0, seq_free = 0, last_exp = 0, credits = sld_pkg::CMD_DEPTH;
   bit load_active = 1'b0, check_on = 1'b0;
   int pop_cyc, ld_base, ld_beat, ld_total, gap_run;

   string       test_name;
   int          test_errs = 0, total_errs = 0, tests_run = 0, tests_failed = 0;
   int          credits_seen = 0;
   logic [31:0] lcg_state = 32'hd70ad7b1;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      return (lcg_next() >> 8) % n;   // low bits of an LCG are weak
   endfunction

   function automatic logic [sld_pkg::VLANE_NUM-1:0] lane_mask(input int k, input int vl);
      for (int l = 0; l < sld_pkg::VLANE_NUM; l++) begin
         lane_mask[l] = (k * sld_pkg::VLANE_NUM + l) < vl;
      end
   endfunction

   // same pattern for every valid lane, zero for the rest
   function automatic logic [31:0] write_enables(input int k, input int sew, input int vl);
      logic [3:0]  pat;
      logic [31:0] bw;
      case (sew)
         sld_pkg::SEW_BYTE: pat = 4'b0001 << (k % 4);
         sld_pkg::SEW_HALF: pat = (k % 2 == 0) ? 4'b0011 : 4'b1100;
         default:           pat = 4'b1111;
      endcase
      bw = '0;
      for (int l = 0; l < sld_pkg::VLANE_NUM; l++) begin
         if (k * sld_pkg::VLANE_NUM + l < vl) bw[4*l +: 4] = pat;
      end
      return bw;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expv,
                              input logic [31:0] actv);
      assert (actv === expv) else begin
         $display("FAIL %s %s cycle %0d: expected %h, actual %h",
                  test_name, what, cyc, expv, actv);
         test_errs++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   task automatic pop_command();
      int kind, vl, sew, dly, ra, wa, n, sh;
      kind = q_kind.pop_front();
      vl   = q_vl.pop_front();
      sew  = q_sew.pop_front();
      dly  = q_dly.pop_front();
      ra   = q_ra.pop_front();
      wa   = q_wa.pop_front();
      void'(q_rdy.pop_front());
      n  = (vl + sld_pkg::VLANE_NUM - 1) / sld_pkg::VLANE_NUM;
      sh = 2 - sew;                            // elements per word 4, 2 or 1
      exp_credit[cyc + 1] = 1'b1;
      seq_free = cyc + 1;
      if (kind == sld_pkg::KIND_NORMAL || kind == sld_pkg::KIND_STORE) begin
         for (int k = 0; k < n; k++) begin
            exp_raddr[cyc + 1 + k] = ra + (k >> sh);
            exp_rdv[cyc + 1 + k]   = lane_mask(k, vl);
            if (kind == sld_pkg::KIND_STORE) begin
               exp_store[cyc + 1 + k] = 1'b1;
            end else begin
               exp_waddr[cyc + 1 + dly + k] = wa + (k >> sh);
               exp_bwen[cyc + 1 + dly + k]  = write_enables(k, sew, vl);
            end
         end
         seq_free = (kind == sld_pkg::KIND_STORE) ? cyc + n : cyc + dly + n;
      end else if (kind == sld_pkg::KIND_LOAD) begin
         load_active = 1'b1;
         pop_cyc     = cyc;
         ld_base     = wa;
         ld_beat     = 0;
         ld_total    = 1 + rand_below(8);
         gap_run     = 0;
      end
      if (seq_free > last_exp) last_exp = seq_free;
   endtask

   task automatic drive_load_beat();
      exp_ready[cyc] = 1'b1;
      if (gap_run == 3 || rand_below(4) != 0) begin
         load_valid_i = 1'b1;
         load_bwen_i  = lcg_next();
         load_last_i  = (ld_beat == ld_total - 1);
         exp_waddr[cyc + 1] = ld_base + ld_beat;   // one word per beat
         exp_bwen[cyc + 1]  = load_bwen_i;
         ld_beat++;
         gap_run = 0;
         if (cyc + 1 > last_exp) last_exp = cyc + 1;
         if (load_last_i) begin
            load_active = 1'b0;
            seq_free    = cyc + 1;
         end
      end else begin
         gap_run++;
      end
   endtask

   task automatic issue_command(input int mode, input int idx);
      int kind, vl, sew, dly, ra, wa;
      kind = sld_pkg::KIND_NORMAL;
      sew  = rand_below(3);
      vl   = 1 + rand_below(64);
      dly  = rand_below(8);
      ra   = rand_below(sld_pkg::MEM_DEPTH);
      wa   = rand_below(sld_pkg::MEM_DEPTH);
      case (mode)
         1: begin
            sew = idx % 3;
            vl  = sld_pkg::VLANE_NUM * (1 + rand_below(8));
         end
         2: dly = (idx % 2 == 0) ? 0 : 200 + rand_below(312);
         3: begin
            kind = rand_below(2) ? sld_pkg::KIND_STORE : sld_pkg::KIND_NORMAL;
            vl   = sld_pkg::VLANE_NUM * rand_below(8) + 1 + rand_below(7);
         end
         4: kind = rand_below(2) ? sld_pkg::KIND_LOAD : sld_pkg::KIND_STORE;
         default: begin
            kind = rand_below(4);               // code 3 included
            if (rand_below(8) == 0) dly = rand_below(512);
         end
      endcase
      cmd_valid_i = 1'b1;
      cmd_kind_i  = kind;
      cmd_vl_i    = vl;
      cmd_sew_i   = sew;
      cmd_delay_i = dly;
      cmd_raddr_i = ra;
      cmd_waddr_i = wa;
      q_kind.push_back(kind);
      q_vl.push_back(vl);
      q_sew.push_back(sew);
      q_dly.push_back(dly);
      q_ra.push_back(ra);
      q_wa.push_back(wa);
      q_rdy.push_back(cyc + 1);                // poppable one cycle after the write
      credits--;
      assert (q_kind.size() <= sld_pkg::CMD_DEPTH) else begin
         $display("%s: more commands outstanding than the queue holds at cycle %0d",
                  test_name, cyc);
         test_errs++;
      end
   endtask

   // one cycle of the dispatcher and the load unit
   task automatic step_model(input int mode, input bit may_issue, inout int issued);
      cmd_valid_i  = 1'b0;
      load_valid_i = 1'b0;
      load_last_i  = 1'b0;
      load_bwen_i  = '0;
      if (credit_o === 1'b1) credits++;         // dispatcher regains a credit per pulse
      if (q_kind.size() != 0 && q_rdy[0] <= cyc && seq_free <= cyc && !load_active) begin
         pop_command();
      end
      if (load_active && cyc > pop_cyc) drive_load_beat();
      if (may_issue && credits > 0 && rand_below(3) != 0) begin
         issue_command(mode, issued);
         issued++;
      end
   endtask

   task automatic end_test();
      tests_run++;
      total_errs += test_errs;
      if (test_errs != 0) tests_failed++;
      $display("test %s: %s, %0d errors", test_name, (test_errs == 0) ? "passed" : "failed",
               test_errs);
   endtask

   task automatic run_test(input string name, input int mode, input int n_cmds);
      int issued;
      issued    = 0;
      test_name = name;
      test_errs = 0;
      while (issued < n_cmds || q_kind.size() != 0 || load_active || cyc < last_exp) begin
         @(posedge clk_i);
         cyc++;
         #1;
         step_model(mode, issued < n_cmds, issued);
      end
      @(negedge clk_i);
      #1;
      end_test();
   endtask

   //////////////////////////////////////////////////////////////////////
   // outputs are stable mid-cycle
   always @(negedge clk_i) begin
      if (check_on) begin
         check_value("vrf_ren_o", exp_raddr.exists(cyc), vrf_ren_o);
         check_value("store_data_valid_o", exp_store.exists(cyc), store_data_valid_o);
         check_value("ready_for_load_o", exp_ready.exists(cyc), ready_for_load_o);
         check_value("credit_o", exp_credit.exists(cyc), credit_o);
         check_value("read_data_valid_o", exp_rdv.exists(cyc) ? exp_rdv[cyc] : '0,
                     read_data_valid_o);
         check_value("vrf_bwen_o", exp_bwen.exists(cyc) ? exp_bwen[cyc] : '0, vrf_bwen_o);
         if (exp_raddr.exists(cyc)) check_value("vrf_raddr_o", exp_raddr[cyc], vrf_raddr_o);
         if (exp_waddr.exists(cyc)) check_value("vrf_waddr_o", exp_waddr[cyc], vrf_waddr_o);
         if (credit_o === 1'b1) credits_seen++;
      end
   end

   initial begin
      #(WATCHDOG_CYC * 8);
      $display("timeout: simulation still running after %0d cycles", WATCHDOG_CYC);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      rstn_i       = 1'b0;
      cmd_valid_i  = 1'b0;
      cmd_kind_i   = '0;
      cmd_vl_i     = '0;
      cmd_sew_i    = '0;
      cmd_delay_i  = '0;
      cmd_raddr_i  = '0;
      cmd_waddr_i  = '0;
      load_valid_i = 1'b0;
      load_last_i  = 1'b0;
      load_bwen_i  = '0;
      test_name    = "reset";
      repeat (8) begin
         @(posedge clk_i);
         cyc++;
         check_on = 1'b1;
      end
      #1 rstn_i = 1'b1;
      repeat (8) begin                         // idle after reset, no credits
         @(posedge clk_i);
         cyc++;
      end
      @(negedge clk_i);
      #1;
      end_test();
      run_test("normal_sew", 1, N_SEW);
      run_test("write_delay", 2, N_DLY);
      run_test("partial_vl", 3, N_TAIL);
      run_test("store_load", 4, N_STLD);
      run_test("random_mix", 5, N_RAND);
      test_name = "credit_return";
      test_errs = 0;
      check_value("credits returned", CMD_TOTAL, credits_seen);
      check_value("credits held", sld_pkg::CMD_DEPTH, credits);
      end_test();
      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               total_errs);
      if (tests_failed == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
sld_pkg.sv
sld_cmd_queue.sv
sld_elem_sequencer.sv
sld_vrf_addr_gen.sv
sld_bwen_gen.sv
sublane_driver.sv
tb_sublane_driver.sv

// File: Bender.yml
package:
  name: sublane_driver

sources:
  - sld_pkg.sv
  - sld_cmd_queue.sv
  - sld_elem_sequencer.sv
  - sld_vrf_addr_gen.sv
  - sld_bwen_gen.sv
  - sublane_driver.sv
  - target: test
    files:
      - tb_sublane_driver.sv
